// File: design/swt16_pkg.sv
`default_nettype none

package swt16_pkg;

   localparam int word_width    = 16;
   localparam int reg_idx_width = 4;
   localparam int num_regs      = 16;
   localparam int opcode_width  = 4;
   localparam int imm_width     = 8;
   localparam int shamt_width   = 4;

   typedef logic [word_width-1:0]    word_t;
   typedef logic [word_width-1:0]    instr_t;
   typedef logic [reg_idx_width-1:0] reg_idx_t;
   typedef logic [imm_width-1:0]     imm_t;

   // Opcode field, bits 15 to 12 of the instruction
   typedef enum logic [opcode_width-1:0] {
      op_nop = 4'd0,
      op_ldi = 4'd1,
      op_add = 4'd2,
      op_sub = 4'd3,
      op_and = 4'd4,
      op_or  = 4'd5,
      op_xor = 4'd6,
      op_sll = 4'd7,
      op_srl = 4'd8,
      op_sra = 4'd9
   } opcode_t;

   typedef enum logic [3:0] {
      alu_pass_imm,
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_sll,
      alu_srl,
      alu_sra
   } alu_op_t;

   // High when the opcode produces a register result
   function automatic logic decode_opcode(input opcode_t opcode, output alu_op_t alu_op);
      logic known;
      known  = 1'b1;
      alu_op = alu_pass_imm;
      case (opcode)
         op_ldi:  alu_op = alu_pass_imm;
         op_add:  alu_op = alu_add;
         op_sub:  alu_op = alu_sub;
         op_and:  alu_op = alu_and;
         op_or:   alu_op = alu_or;
         op_xor:  alu_op = alu_xor;
         op_sll:  alu_op = alu_sll;
         op_srl:  alu_op = alu_srl;
         op_sra:  alu_op = alu_sra;
         default: known = 1'b0;
      endcase
      return known;
   endfunction

endpackage

`default_nettype wire

// File: design/swt16_stage_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded operation, decode to execute
interface op_if import swt16_pkg::*; ();
   logic     valid;
   logic     ready;
   alu_op_t  alu_op;
   reg_idx_t dst_idx;
   reg_idx_t src1_idx;
   reg_idx_t src2_idx;
   imm_t     imm;

   modport source (output valid, output alu_op, output dst_idx, output src1_idx,
                   output src2_idx, output imm, input ready);

   modport sink (input valid, input alu_op, input dst_idx, input src1_idx,
                 input src2_idx, input imm, output ready);
endinterface

// Register result, execute to writeback
interface res_if import swt16_pkg::*; ();
   logic     valid;
   logic     ready;
   reg_idx_t dst_idx;
   word_t    data;

   modport source (output valid, output dst_idx, output data, input ready);

   modport sink (input valid, input dst_idx, input data, output ready);
endinterface

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import swt16_pkg::*; (
   input  wire           clock,
   input  wire           rst,
   input  wire           write,
   input  wire reg_idx_t write_idx,
   input  wire word_t    write_data,
   input  wire reg_idx_t rd1_idx,
   input  wire reg_idx_t rd2_idx,
   output word_t         rd1_data,
   output word_t         rd2_data
);

   word_t regs [num_regs];

   always_ff @(posedge clock) begin
      if (rst) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (write) begin
         regs[write_idx] <= write_data;
      end
   end

   // Reads see the old value during a write
   assign rd1_data = regs[rd1_idx];
   assign rd2_data = regs[rd2_idx];

   write_idx_known: assert property (
      @(posedge clock) disable iff (rst)
      write |-> !$isunknown(write_idx)
   );

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import swt16_pkg::*; (
   input  wire         clock,
   input  wire         rst,
   input  wire         instr_valid,
   input  wire instr_t instr,
   output logic        instr_ready,
   op_if.source        op
);

   opcode_t  opcode;
   reg_idx_t dst_idx;
   reg_idx_t src1_idx;
   reg_idx_t src2_idx;
   imm_t     imm;
   alu_op_t  dec_alu_op;
   logic     dec_valid;

   // Instruction fields
   assign opcode   = opcode_t'(instr[15:12]);
   assign dst_idx  = instr[11:8];
   assign src1_idx = instr[7:4];
   assign src2_idx = instr[3:0];
   assign imm      = instr[imm_width-1:0];

   always_comb begin
      dec_valid = decode_opcode(opcode, dec_alu_op);
   end

   // Room when empty or when execute takes the current op
   assign instr_ready = !op.valid || op.ready;

   always_ff @(posedge clock) begin
      if (rst) begin
         op.valid    <= 1'b0;
         op.alu_op   <= alu_pass_imm;
         op.dst_idx  <= '0;
         op.src1_idx <= '0;
         op.src2_idx <= '0;
         op.imm      <= '0;
      end else if (instr_ready) begin
         // nop and undefined codes are consumed here
         op.valid <= instr_valid && dec_valid;
         if (instr_valid && dec_valid) begin
            op.alu_op   <= dec_alu_op;
            op.dst_idx  <= dst_idx;
            op.src1_idx <= src1_idx;
            op.src2_idx <= src2_idx;
            op.imm      <= imm;
         end
      end
   end

   op_held_until_taken: assert property (
      @(posedge clock) disable iff (rst)
      op.valid && !op.ready |=> op.valid && $stable(op.dst_idx) && $stable(op.alu_op)
   );

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage import swt16_pkg::*; (
   input  wire        clock,
   input  wire        rst,
   op_if.sink         op,
   output reg_idx_t   rd1_idx,
   output reg_idx_t   rd2_idx,
   input  wire word_t rd1_data,
   input  wire word_t rd2_data,
   res_if.source      res
);

   word_t                  src1;
   word_t                  src2;
   word_t                  neg_src2;
   word_t                  alu_res;
   logic [shamt_width-1:0] shamt;
   logic                   byp1;
   logic                   byp2;

   assign rd1_idx = op.src1_idx;
   assign rd2_idx = op.src2_idx;

   // Own result register is the only value not yet in the register file
   assign byp1 = res.valid && (res.dst_idx == op.src1_idx);
   assign byp2 = res.valid && (res.dst_idx == op.src2_idx);

   assign src1 = byp1 ? res.data : rd1_data;
   assign src2 = byp2 ? res.data : rd2_data;

   assign shamt    = src2[shamt_width-1:0];
   assign neg_src2 = ~src2 + word_t'(1);

   always_comb begin
      case (op.alu_op)
         alu_pass_imm: alu_res = word_t'(op.imm);
         alu_add:      alu_res = src1 + src2;
         alu_sub:      alu_res = src1 + neg_src2;
         alu_and:      alu_res = src1 & src2;
         alu_or:       alu_res = src1 | src2;
         alu_xor:      alu_res = src1 ^ src2;
         alu_sll:      alu_res = src1 << shamt;
         alu_srl:      alu_res = src1 >> shamt;
         // Fills with the sign bit
         alu_sra:      alu_res = word_t'($signed(src1) >>> shamt);
         default:      alu_res = '0;
      endcase
   end

   assign op.ready = !res.valid || res.ready;

   always_ff @(posedge clock) begin
      if (rst) begin
         res.valid   <= 1'b0;
         res.dst_idx <= '0;
         res.data    <= '0;
      end else if (op.ready) begin
         res.valid <= op.valid;
         if (op.valid) begin
            res.dst_idx <= op.dst_idx;
            res.data    <= alu_res;
         end
      end
   end

   res_held_until_taken: assert property (
      @(posedge clock) disable iff (rst)
      res.valid && !res.ready |=> res.valid && $stable(res.data) && $stable(res.dst_idx)
   );

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import swt16_pkg::*; (
   input  wire  clock,
   input  wire  rst,
   res_if.sink  res,
   output logic reg_write,
   output reg_idx_t reg_write_idx,
   output word_t    reg_write_data,
   output logic     wb_valid,
   input  wire      wb_ready,
   output reg_idx_t wb_reg_idx,
   output word_t    wb_data
);

   assign res.ready = !wb_valid || wb_ready;

   // Register file updated on the same edge that loads the output register
   assign reg_write      = res.valid && res.ready;
   assign reg_write_idx  = res.dst_idx;
   assign reg_write_data = res.data;

   always_ff @(posedge clock) begin
      if (rst) begin
         wb_valid   <= 1'b0;
         wb_reg_idx <= '0;
         wb_data    <= '0;
      end else if (res.ready) begin
         wb_valid <= res.valid;
         if (res.valid) begin
            wb_reg_idx <= res.dst_idx;
            wb_data    <= res.data;
         end
      end
   end

   wb_stable_when_stalled: assert property (
      @(posedge clock) disable iff (rst)
      wb_valid && !wb_ready |=> wb_valid && $stable(wb_data) && $stable(wb_reg_idx)
   );

endmodule

`default_nettype wire

// File: design/swt16_top.sv
`timescale 1ns/1ps
`default_nettype none

module swt16_top import swt16_pkg::*; (
   input  wire         clock,
   input  wire         rst,
   input  wire         instr_valid,
   input  wire instr_t instr,
   output wire         instr_ready,
   output wire         wb_valid,
   input  wire         wb_ready,
   output reg_idx_t    wb_reg_idx,
   output word_t       wb_data
);

   logic     reg_write;
   reg_idx_t reg_write_idx;
   word_t    reg_write_data;
   reg_idx_t rd1_idx;
   reg_idx_t rd2_idx;
   word_t    rd1_data;
   word_t    rd2_data;

   op_if  op_bus ();
   res_if res_bus ();

   regfile regfile_i (
      .clock      (clock),
      .rst        (rst),
      .write      (reg_write),
      .write_idx  (reg_write_idx),
      .write_data (reg_write_data),
      .rd1_idx    (rd1_idx),
      .rd2_idx    (rd2_idx),
      .rd1_data   (rd1_data),
      .rd2_data   (rd2_data)
   );

   decode_stage decode_stage_i (
      .clock       (clock),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ready (instr_ready),
      .op          (op_bus.source)
   );

   exec_stage exec_stage_i (
      .clock    (clock),
      .rst      (rst),
      .op       (op_bus.sink),
      .rd1_idx  (rd1_idx),
      .rd2_idx  (rd2_idx),
      .rd1_data (rd1_data),
      .rd2_data (rd2_data),
      .res      (res_bus.source)
   );

   writeback_stage writeback_stage_i (
      .clock          (clock),
      .rst            (rst),
      .res            (res_bus.sink),
      .reg_write      (reg_write),
      .reg_write_idx  (reg_write_idx),
      .reg_write_data (reg_write_data),
      .wb_valid       (wb_valid),
      .wb_ready       (wb_ready),
      .wb_reg_idx     (wb_reg_idx),
      .wb_data        (wb_data)
   );

endmodule

`default_nettype wire

// File: tests/swt16_tb.sv
`timescale 1ns/1ps
`default_nettype none

module swt16_tb import swt16_pkg::*; ();

   localparam int accept_limit = 200;
   localparam int drain_limit  = 400;
   localparam int num_random   = 48;

   typedef struct packed {
      instr_t instr;
      logic   has_result;
   } entry_t;

   typedef struct packed {
      reg_idx_t idx;
      word_t    data;
      int       accept_edge;
      logic     timed;
   } expect_t;

   logic        clock;
   logic        rst;
   logic        instr_valid;
   instr_t      instr;
   logic        instr_ready;
   logic        wb_valid;
   logic        wb_ready;
   reg_idx_t    wb_reg_idx;
   word_t       wb_data;

   entry_t      table_q[$];
   expect_t     exp_q[$];
   word_t       model_regs [num_regs];
   logic [31:0] rng;
   int          edge_count;
   int          error_count;
   int          timeout_count;
   int          out_count;
   logic        timed_out;
   logic        random_ready;
   logic        latency_mode;

   swt16_top swt16_top_i (
      .clock       (clock),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ready (instr_ready),
      .wb_valid    (wb_valid),
      .wb_ready    (wb_ready),
      .wb_reg_idx  (wb_reg_idx),
      .wb_data     (wb_data)
   );

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   always @(posedge clock) begin
      edge_count <= edge_count + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic instr_t enc_rrr(input opcode_t op, input int d, input int s1, input int s2);
      return {op, reg_idx_t'(d), reg_idx_t'(s1), reg_idx_t'(s2)};
   endfunction

   function automatic instr_t enc_ldi(input int d, input imm_t v);
      return {op_ldi, reg_idx_t'(d), v};
   endfunction

   // Reference register model, follows the opcode map
   function automatic word_t model_apply(input instr_t i);
      word_t      a;
      word_t      b;
      word_t      res;
      logic [3:0] sh;
      logic       known;
      a     = model_regs[i[7:4]];
      b     = model_regs[i[3:0]];
      sh    = b[3:0];
      known = 1'b1;
      res   = '0;
      case (i[15:12])
         4'd1:    res = {8'h00, i[7:0]};
         4'd2:    res = a + b;
         4'd3:    res = a - b;
         4'd4:    res = a & b;
         4'd5:    res = a | b;
         4'd6:    res = a ^ b;
         4'd7:    res = a << sh;
         4'd8:    res = a >> sh;
         4'd9: begin
            // Vacated top bits take the sign
            res = a >> sh;
            if (a[15]) begin
               res = res | ~(16'hffff >> sh);
            end
         end
         default: known = 1'b0;
      endcase
      if (known) begin
         model_regs[i[11:8]] = res;
      end
      return res;
   endfunction

   task automatic compare_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
      if (act !== exp) begin
         error_count++;
         $display("[ERROR] %s: expected r%0d, actual r%0d", name, exp, act);
      end
   endtask

   task automatic compare_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         error_count++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         error_count++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic compare_count(input string name, input int exp, input int act);
      if (act != exp) begin
         error_count++;
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic add_entry(input instr_t i, input logic has_result);
      entry_t e;
      e.instr      = i;
      e.has_result = has_result;
      table_q.push_back(e);
   endtask

   task automatic build_table();
      instr_t ri;
      // Registers read as zero after reset
      add_entry(enc_rrr(op_or, 2, 5, 9), 1'b1);
      for (int r = 0; r < num_regs; r++) begin
         add_entry(enc_ldi(r, {r[3:0], ~r[3:0]}), 1'b1);
      end
      // Back to back dependent chain
      add_entry(enc_rrr(op_add, 1, 2, 3), 1'b1);
      add_entry(enc_rrr(op_sub, 4, 1, 2), 1'b1);
      add_entry(enc_rrr(op_and, 5, 4, 1), 1'b1);
      add_entry(enc_rrr(op_or, 6, 5, 4), 1'b1);
      add_entry(enc_rrr(op_xor, 7, 6, 5), 1'b1);
      add_entry(enc_rrr(op_add, 7, 7, 7), 1'b1);
      add_entry(enc_rrr(op_sub, 8, 7, 8), 1'b1);
      // Shifts of a negative value, shamt from low 4 bits
      add_entry(enc_ldi(0, 8'h00), 1'b1);
      add_entry(enc_ldi(9, 8'h80), 1'b1);
      add_entry(enc_rrr(op_sub, 10, 0, 9), 1'b1);
      add_entry(enc_ldi(11, 8'h13), 1'b1);
      add_entry(enc_rrr(op_sra, 12, 10, 11), 1'b1);
      add_entry(enc_rrr(op_srl, 13, 10, 11), 1'b1);
      add_entry(enc_rrr(op_sll, 14, 10, 11), 1'b1);
      add_entry(enc_ldi(11, 8'h0f), 1'b1);
      add_entry(enc_rrr(op_sra, 12, 10, 11), 1'b1);
      // nop and undefined codes aimed at r1
      add_entry(16'h01ff, 1'b0);
      add_entry(16'ha1ff, 1'b0);
      add_entry(16'hf123, 1'b0);
      add_entry(enc_rrr(op_add, 15, 1, 1), 1'b1);
      for (int k = 0; k < num_random; k++) begin
         rng = xorshift32(rng);
         ri  = rng[15:0];
         add_entry(ri, ri[15:12] >= 4'd1 && ri[15:12] <= 4'd9);
      end
   endtask

   task automatic issue_entry(input int n, input entry_t e);
      int      waited;
      expect_t x;
      @(negedge clock);
      instr_valid = 1'b1;
      instr       = e.instr;
      waited      = 0;
      do begin
         @(posedge clock);
         waited++;
      end while (!instr_ready && waited < accept_limit);
      if (!instr_ready) begin
         timeout_count++;
         timed_out = 1'b1;
         $display("Timeout: instruction %0d was not accepted within %0d cycles", n, accept_limit);
      end else begin
         // One instruction per cycle without back-pressure
         if (latency_mode) begin
            compare_count($sformatf("instruction %0d accept cycles", n), 1, waited);
         end
         x.idx         = e.instr[11:8];
         x.data        = model_apply(e.instr);
         x.accept_edge = edge_count;
         x.timed       = latency_mode;
         if (e.has_result) begin
            exp_q.push_back(x);
         end
      end
   endtask

   task automatic drain_results();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < drain_limit) begin
         @(posedge clock);
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeout_count++;
         timed_out = 1'b1;
         $display("Timeout: %0d results never came out of the pipeline", exp_q.size());
      end
      // Catch any stray output
      repeat (4) @(posedge clock);
   endtask

   always @(negedge clock) begin
      if (random_ready) begin
         rng      = xorshift32(rng);
         wb_ready = (rng[2:0] > 3'd2);
      end else begin
         wb_ready = 1'b1;
      end
   end

   always @(posedge clock) begin : monitor
      expect_t x;
      if (!rst && wb_valid && wb_ready) begin
         if (exp_q.size() == 0) begin
            error_count++;
            $display("Unexpected result for r%0d with no instruction pending", wb_reg_idx);
         end else begin
            x = exp_q.pop_front();
            compare_idx($sformatf("result %0d index", out_count), x.idx, wb_reg_idx);
            compare_word($sformatf("result %0d data", out_count), x.data, wb_data);
            if (x.timed) begin
               compare_count($sformatf("result %0d latency", out_count), 3,
                             edge_count - x.accept_edge);
            end
         end
         out_count++;
      end
   end

   initial begin
      rst           = 1'b1;
      instr_valid   = 1'b0;
      instr         = '0;
      wb_ready      = 1'b0;
      rng           = 32'h7bc8;
      edge_count    = 0;
      error_count   = 0;
      timeout_count = 0;
      out_count     = 0;
      timed_out     = 1'b0;
      random_ready  = 1'b0;
      latency_mode  = 1'b1;
      for (int r = 0; r < num_regs; r++) begin
         model_regs[r] = '0;
      end
      build_table();

      repeat (5) @(posedge clock);
      @(negedge clock);
      rst = 1'b0;
      @(negedge clock);
      compare_bit("wb_valid after reset", 1'b0, wb_valid);
      compare_bit("instr_ready after reset", 1'b1, instr_ready);

      // wb_ready held high, fixed latency expected
      for (int n = 0; n < table_q.size() && !timed_out; n++) begin
         issue_entry(n, table_q[n]);
      end
      @(negedge clock);
      instr_valid = 1'b0;
      drain_results();

      // Random back-pressure on the result stream
      @(posedge clock);
      random_ready = 1'b1;
      latency_mode = 1'b0;
      for (int n = 0; n < table_q.size() && !timed_out; n++) begin
         issue_entry(n, table_q[n]);
      end
      @(negedge clock);
      instr_valid = 1'b0;
      drain_results();

      $display("Results %0d, value errors %0d, timeouts %0d",
               out_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
design/swt16_pkg.sv
design/swt16_stage_ifs.sv
design/regfile.sv
design/decode_stage.sv
design/exec_stage.sv
design/writeback_stage.sv
design/swt16_top.sv
tests/swt16_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the swt16 pipeline testbench with Verilator
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f filelist.f --top-module swt16_tb -o swt16_sim \
   && obj_dir/swt16_sim | tee /dev/stderr | grep -q "Test completed successfully" \
   && echo "PASS" \
   && exit 0 \
   || { echo "FAIL"; exit 1; }
